/* source/lmx_pkg.sv */
`default_nettype none

package lmx_pkg;

  typedef logic [31:0] lmx_word_t;   // programming word / bus data
  typedef logic [4:0]  lmx_count_t;  // buffer fill level, depth <= 16

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_shift,
    st_lastbit,
    st_latch
  } spi_state_t;

  // register map
  localparam lmx_word_t addr_word   = 32'h0000_0000;
  localparam lmx_word_t addr_status = 32'h0000_0004;
  localparam lmx_word_t addr_ctrl   = 32'h0000_0008;

  // status word layout, fill count sits in 4:0
  localparam int status_busy_bit   = 8;
  localparam int status_muxout_bit = 9;

endpackage

`default_nettype wire

/* source/lmx_wb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module lmx_wb_regs import lmx_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  lmx_word_t  wb_adr_i,
  input  lmx_word_t  wb_dat_i,
  input  logic [3:0] wb_sel_i,
  input  logic       wb_we_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  output lmx_word_t  wb_dat_o,
  output logic       wb_ack_o,
  output logic       wb_err_o,
  input  logic       lmx_muxout_i,
  output logic       lmx_ce_o,
  output logic       lmx_be_o,
  output logic       push_req_o,
  output lmx_word_t  push_word_o,
  input  logic       push_ack_i,
  input  lmx_count_t fill_count_i,
  input  logic       busy_i
);

  logic       bus_req;
  logic       word_wr;
  logic       ctrl_acc;
  logic       status_rd;
  logic [1:0] ctrl_q;
  logic [1:0] muxout_q;
  lmx_word_t  status_word;
  lmx_word_t  rd_q;
  lmx_word_t  sel_mask;

  // new access, not yet answered
  assign bus_req   = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign word_wr   = (wb_adr_i == addr_word) && wb_we_i;
  assign ctrl_acc  = (wb_adr_i == addr_ctrl);
  assign status_rd = (wb_adr_i == addr_status) && !wb_we_i;

  assign sel_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

  always_comb begin
    status_word = '0;
    status_word[$bits(lmx_count_t)-1:0] = fill_count_i;
    status_word[status_busy_bit]        = busy_i;
    status_word[status_muxout_bit]      = muxout_q[1];
  end

  always_ff @(posedge wb_clk_i) begin
    muxout_q <= {muxout_q[0], lmx_muxout_i};  // pin is asynchronous
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      wb_err_o   <= 1'b0;
      push_req_o <= 1'b0;
      ctrl_q     <= 2'b00;
    end else begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      if (push_req_o) begin
        if (push_ack_i) begin  // buffer took the word
          push_req_o <= 1'b0;
          wb_ack_o   <= 1'b1;
        end
      end else if (bus_req) begin
        if (word_wr) begin
          // previous handshake must be fully closed first
          if (!push_ack_i) begin
            push_req_o <= 1'b1;
          end
        end else if (ctrl_acc) begin
          wb_ack_o <= 1'b1;
          if (wb_we_i && wb_sel_i[0]) begin
            ctrl_q <= wb_dat_i[1:0];
          end
        end else if (status_rd) begin
          wb_ack_o <= 1'b1;
        end else begin
          wb_err_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (bus_req && word_wr && !push_req_o && !push_ack_i) begin
      push_word_o <= wb_dat_i & sel_mask;  // unselected bytes read as zero
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (bus_req) begin
      if (wb_we_i) begin
        rd_q <= '0;
      end else if (ctrl_acc) begin
        rd_q <= {30'b0, ctrl_q};
      end else begin
        rd_q <= status_word;
      end
    end
  end

  assign wb_dat_o = wb_ack_o ? rd_q : '0;
  assign lmx_ce_o = ctrl_q[0];
  assign lmx_be_o = ctrl_q[1];

endmodule

`default_nettype wire

/* source/lmx_cmd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module lmx_cmd_fifo import lmx_pkg::*; #(
  parameter int fifo_depth_log2 = 2
) (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  logic       push_req_i,
  input  lmx_word_t  push_word_i,
  output logic       push_ack_o,
  output logic       pop_req_o,
  output lmx_word_t  pop_word_o,
  input  logic       pop_ack_i,
  output lmx_count_t fill_count_o
);

  localparam int depth = 1 << fifo_depth_log2;

  lmx_word_t                  mem [depth];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;
  logic                       full;
  logic                       empty;
  logic                       do_push;
  logic                       do_pop;

  assign full    = (fill_count_o == lmx_count_t'(depth));
  assign empty   = (fill_count_o == '0);
  assign do_push = push_req_i && !push_ack_o && !full;
  assign do_pop  = pop_req_o && pop_ack_i;

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_word_i;
    end
  end

  assign pop_word_o = mem[rd_ptr];  // head word, steady while req is up

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill_count_o <= '0;
      push_ack_o   <= 1'b0;
      pop_req_o    <= 1'b0;
    end else begin
      fill_count_o <= fill_count_o + lmx_count_t'(do_push) - lmx_count_t'(do_pop);
      // push side
      if (do_push) begin
        wr_ptr     <= wr_ptr + 1'b1;
        push_ack_o <= 1'b1;
      end else if (push_ack_o && !push_req_i) begin
        push_ack_o <= 1'b0;
      end
      // pop side
      if (do_pop) begin
        rd_ptr    <= rd_ptr + 1'b1;
        pop_req_o <= 1'b0;
      end else if (!pop_req_o && !pop_ack_i && !empty) begin
        pop_req_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/lmx_spi_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module lmx_spi_shifter import lmx_pkg::*; #(
  parameter int spi_clk_div_bits = 5
) (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  logic      pop_req_i,
  input  lmx_word_t pop_word_i,
  output logic      pop_ack_o,
  output logic      busy_o,
  output logic      lmx_clk_o,
  output logic      lmx_data_o,
  output logic      lmx_le_o
);

  logic [spi_clk_div_bits-1:0] div_cnt;
  logic                        spi_clk;
  logic                        spi_clk_z;
  logic                        spi_clk_rise;
  logic                        spi_clk_fall;
  logic                        take;
  logic                        clk_en;
  logic [4:0]                  bit_cnt;
  lmx_word_t                   shift_q;
  spi_state_t                  state;

  assign spi_clk      = div_cnt[spi_clk_div_bits-1];
  assign spi_clk_rise = spi_clk && !spi_clk_z;
  assign spi_clk_fall = !spi_clk && spi_clk_z;
  assign take         = (state == st_idle) && pop_req_i && !pop_ack_o;

  // free running, restarted on each new word
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || take) begin
      div_cnt   <= '0;
      spi_clk_z <= 1'b0;
    end else begin
      div_cnt   <= div_cnt + 1'b1;
      spi_clk_z <= spi_clk;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state     <= st_idle;
      pop_ack_o <= 1'b0;
      clk_en    <= 1'b0;
      lmx_le_o  <= 1'b0;
      bit_cnt   <= '0;
      shift_q   <= '0;
    end else begin
      if (pop_ack_o && !pop_req_i) begin
        pop_ack_o <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (take) begin
            shift_q   <= pop_word_i;  // msb goes out first
            pop_ack_o <= 1'b1;
            state     <= st_start;
          end
        end
        st_start: begin
          if (spi_clk_fall) begin
            clk_en  <= 1'b1;
            bit_cnt <= '0;
            state   <= st_shift;
          end
        end
        st_shift: begin
          if (spi_clk_rise) begin
            if (bit_cnt == 5'd31) begin
              state <= st_lastbit;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          if (spi_clk_fall) begin
            shift_q <= {shift_q[30:0], 1'b0};
          end
        end
        st_lastbit: begin
          if (spi_clk_fall) begin
            clk_en   <= 1'b0;
            lmx_le_o <= 1'b1;  // half a serial period
            state    <= st_latch;
          end
        end
        st_latch: begin
          if (spi_clk_rise) begin
            lmx_le_o <= 1'b0;
            state    <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign busy_o     = (state != st_idle);
  assign lmx_clk_o  = spi_clk && clk_en;
  assign lmx_data_o = shift_q[31];

endmodule

`default_nettype wire

/* source/lmx_spi_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lmx_spi_ctrl_top import lmx_pkg::*; #(
  parameter int spi_clk_div_bits = 5,
  parameter int fifo_depth_log2  = 2
) (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  lmx_word_t  wb_adr_i,
  input  lmx_word_t  wb_dat_i,
  input  logic [3:0] wb_sel_i,
  input  logic       wb_we_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  output lmx_word_t  wb_dat_o,
  output logic       wb_ack_o,
  output logic       wb_err_o,
  input  logic       lmx_muxout_i,
  output logic       lmx_clk_o,
  output logic       lmx_data_o,
  output logic       lmx_le_o,
  output logic       lmx_ce_o,
  output logic       lmx_be_o
);

  logic       push_req;
  lmx_word_t  push_word;
  logic       push_ack;
  logic       pop_req;
  lmx_word_t  pop_word;
  logic       pop_ack;
  lmx_count_t fill_count;
  logic       busy;

  lmx_wb_regs u_regs (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .lmx_muxout_i (lmx_muxout_i),
    .lmx_ce_o     (lmx_ce_o),
    .lmx_be_o     (lmx_be_o),
    .push_req_o   (push_req),
    .push_word_o  (push_word),
    .push_ack_i   (push_ack),
    .fill_count_i (fill_count),
    .busy_i       (busy)
  );

  lmx_cmd_fifo #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) u_fifo (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .push_req_i   (push_req),
    .push_word_i  (push_word),
    .push_ack_o   (push_ack),
    .pop_req_o    (pop_req),
    .pop_word_o   (pop_word),
    .pop_ack_i    (pop_ack),
    .fill_count_o (fill_count)
  );

  lmx_spi_shifter #(
    .spi_clk_div_bits (spi_clk_div_bits)
  ) u_shifter (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .pop_req_i  (pop_req),
    .pop_word_i (pop_word),
    .pop_ack_o  (pop_ack),
    .busy_o     (busy),
    .lmx_clk_o  (lmx_clk_o),
    .lmx_data_o (lmx_data_o),
    .lmx_le_o   (lmx_le_o)
  );

endmodule

`default_nettype wire

/* test/lmx_spi_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module lmx_spi_checker import lmx_pkg::*; (
  input logic      wb_clk_i,
  input logic      wb_rst_i,
  input logic      wb_ack_i,
  input logic      wb_err_i,
  input lmx_word_t wb_dat_i,
  input logic      lmx_clk_i,
  input logic      lmx_data_i,
  input logic      lmx_le_i
);

  lmx_word_t exp_q [$];  // frames still to come, in write order
  lmx_word_t frame_q;
  int        bit_cnt;
  int        error_count = 0;
  int        check_count = 0;
  logic      clk_z;
  logic      le_z;

  function automatic int frames_pending();
    return exp_q.size();
  endfunction

  task automatic expect_frame(input lmx_word_t word);
    exp_q.push_back(word);
  endtask

  task automatic check_value(input string name, input lmx_word_t expected,
                             input lmx_word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("t=%0t %s", $time, what);
  endtask

  // mid-cycle sampling, all DUT outputs settled
  always @(negedge wb_clk_i) begin
    if (wb_rst_i) begin
      clk_z   = 1'b0;
      le_z    = 1'b0;
      bit_cnt = 0;
      frame_q = '0;
    end else begin
      if (lmx_clk_i && !clk_z) begin  // chip samples on rising edge
        frame_q = {frame_q[30:0], lmx_data_i};
        bit_cnt = bit_cnt + 1;
      end
      if (lmx_le_i && !le_z) begin
        check_value("frame_bits", 32, bit_cnt);
        if (exp_q.size() == 0) begin
          report_failure($sformatf("frame %h arrived but none was expected", frame_q));
        end else begin
          check_value("lmx_data_o frame", exp_q.pop_front(), frame_q);
        end
        bit_cnt = 0;
      end
      if (lmx_le_i && lmx_clk_i) begin
        report_failure("serial clock is running while latch enable is high");
      end
      if (wb_ack_i && wb_err_i) begin
        report_failure("wishbone ack and err are high together");
      end
      if (!wb_ack_i && wb_dat_i !== '0) begin
        check_value("wb_dat_o", '0, wb_dat_i);  // data only valid with ack
      end
      clk_z = lmx_clk_i;
      le_z  = lmx_le_i;
    end
  end

endmodule

`default_nettype wire

/* test/lmx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lmx_tb import lmx_pkg::*; ();

  localparam int op_wr         = 0;
  localparam int op_rd         = 1;
  localparam int op_pin        = 2;  // drive mux-out level
  localparam int op_ctl_pins   = 3;  // compare be/ce pins
  localparam int op_drain      = 4;  // wait for all frames
  localparam int max_steps     = 64;
  localparam int bus_timeout   = 4000;
  localparam int drain_timeout = 12000;

  logic       wb_clk_i;
  logic       wb_rst_i;
  lmx_word_t  wb_adr_i;
  lmx_word_t  wb_dat_i;
  logic [3:0] wb_sel_i;
  logic       wb_we_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  lmx_word_t  wb_dat_o;
  logic       wb_ack_o;
  logic       wb_err_o;
  logic       lmx_muxout_i;
  logic       lmx_clk_o;
  logic       lmx_data_o;
  logic       lmx_le_o;
  logic       lmx_ce_o;
  logic       lmx_be_o;

  int         step_op   [max_steps];
  lmx_word_t  step_adr  [max_steps];
  lmx_word_t  step_dat  [max_steps];
  logic [3:0] step_sel  [max_steps];
  logic       step_err  [max_steps];
  lmx_word_t  step_exp  [max_steps];
  lmx_word_t  step_mask [max_steps];
  int         n_steps = 0;
  int         seed_val;
  logic       mux_lvl;

  lmx_spi_ctrl_top #(
    .spi_clk_div_bits (5),
    .fifo_depth_log2  (2)
  ) uut (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_sel_i     (wb_sel_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .lmx_muxout_i (lmx_muxout_i),
    .lmx_clk_o    (lmx_clk_o),
    .lmx_data_o   (lmx_data_o),
    .lmx_le_o     (lmx_le_o),
    .lmx_ce_o     (lmx_ce_o),
    .lmx_be_o     (lmx_be_o)
  );

  lmx_spi_checker chk (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_ack_i   (wb_ack_o),
    .wb_err_i   (wb_err_o),
    .wb_dat_i   (wb_dat_o),
    .lmx_clk_i  (lmx_clk_o),
    .lmx_data_i (lmx_data_o),
    .lmx_le_i   (lmx_le_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #10 wb_clk_i = ~wb_clk_i;
  end

  function automatic lmx_word_t keep_selected_bytes(input lmx_word_t dat, input logic [3:0] sel);
    lmx_word_t res;
    res = '0;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic add_step(input int op, input lmx_word_t adr, input lmx_word_t dat,
                          input logic [3:0] sel, input logic err, input lmx_word_t exp,
                          input lmx_word_t mask);
    step_op[n_steps]   = op;
    step_adr[n_steps]  = adr;
    step_dat[n_steps]  = dat;
    step_sel[n_steps]  = sel;
    step_err[n_steps]  = err;
    step_exp[n_steps]  = exp;
    step_mask[n_steps] = mask;
    n_steps++;
  endtask

  // expected frame is the word with unselected bytes cleared
  task automatic add_word(input lmx_word_t dat, input logic [3:0] sel);
    add_step(op_wr, addr_word, dat, sel, 1'b0, keep_selected_bytes(dat, sel), '1);
  endtask

  task automatic build_table();
    add_step(op_rd, addr_ctrl, 0, 4'hf, 1'b0, 0, '1);
    add_step(op_ctl_pins, 0, 0, 4'h0, 1'b0, 0, '1);
    add_step(op_rd, addr_status, 0, 4'hf, 1'b0, 0, '1);
    for (int v = 2; v >= 0; v--) begin
      add_step(op_wr, addr_ctrl, 3 - v, 4'hf, 1'b0, 0, '1);
      add_step(op_rd, addr_ctrl, 0, 4'hf, 1'b0, 3 - v, '1);
      add_step(op_ctl_pins, 0, 0, 4'h0, 1'b0, 3 - v, '1);
    end
    for (int p = 0; p < 2; p++) begin
      mux_lvl = (p == 0) ? 1'($urandom()) : !mux_lvl;
      add_step(op_pin, 0, lmx_word_t'(mux_lvl), 4'h0, 1'b0, 0, 0);
      add_step(op_rd, addr_status, 0, 4'hf, 1'b0,
               lmx_word_t'(mux_lvl) << status_muxout_bit, '1);
    end
    add_word($urandom(), 4'hf);
    add_word(32'ha5c3_0f96, 4'b0101);
    add_step(op_drain, 0, 0, 4'h0, 1'b0, 0, 0);
    add_step(op_rd, 32'hc, 0, 4'hf, 1'b1, 0, 0);
    add_step(op_wr, 32'hc, $urandom(), 4'hf, 1'b1, 0, 0);
    add_step(op_wr, addr_status, $urandom(), 4'hf, 1'b1, 0, 0);
    add_step(op_rd, addr_word, 0, 4'hf, 1'b1, 0, 0);
    for (int k = 0; k < 6; k++) begin  // overruns the 4-deep buffer
      add_word($urandom(), (k == 2) ? 4'b1000 : 4'hf);
    end
    add_step(op_rd, addr_status, 0, 4'hf, 1'b0, 1 << status_busy_bit, 1 << status_busy_bit);
    add_step(op_drain, 0, 0, 4'h0, 1'b0, 0, 0);
    add_step(op_rd, addr_status, 0, 4'hf, 1'b0,
             lmx_word_t'(mux_lvl) << status_muxout_bit, '1);
    add_step(op_wr, addr_ctrl, 0, 4'hf, 1'b0, 0, '1);
    add_step(op_ctl_pins, 0, 0, 4'h0, 1'b0, 0, '1);
  endtask

  task automatic bus_access(input logic we, input lmx_word_t adr, input lmx_word_t dat,
                            input logic [3:0] sel, output logic got_err,
                            output lmx_word_t rdata, output logic done);
    int n;
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    done     = 1'b0;
    got_err  = 1'b0;
    rdata    = '0;
    n        = 0;
    while (!done && n < bus_timeout) begin  // word writes may stall a long time
      @(negedge wb_clk_i);
      if (wb_ack_o || wb_err_o) begin
        done    = 1'b1;
        got_err = wb_err_o;
        rdata   = wb_dat_o;
      end
      n++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!done) begin
      chk.report_failure($sformatf("no wishbone response at address %h in time", adr));
    end
  endtask

  task automatic run_step(input int idx);
    logic      got_err;
    lmx_word_t rdata;
    logic      done;
    int        n;
    case (step_op[idx])
      op_wr, op_rd: begin
        if (step_op[idx] == op_wr && step_adr[idx] == addr_word && !step_err[idx]) begin
          chk.expect_frame(step_exp[idx]);
        end
        bus_access(step_op[idx] == op_wr, step_adr[idx], step_dat[idx], step_sel[idx],
                   got_err, rdata, done);
        if (done) begin
          chk.check_value("wb_err_o", lmx_word_t'(step_err[idx]), lmx_word_t'(got_err));
          if (step_op[idx] == op_rd && !got_err) begin
            chk.check_value("wb_dat_o", step_exp[idx] & step_mask[idx],
                            rdata & step_mask[idx]);
          end
        end
      end
      op_pin: begin
        @(negedge wb_clk_i);
        lmx_muxout_i = step_dat[idx][0];
        repeat (4) @(negedge wb_clk_i);  // through the two sync flops
      end
      op_ctl_pins: begin
        chk.check_value("lmx_be_o,lmx_ce_o", step_exp[idx], {30'b0, lmx_be_o, lmx_ce_o});
      end
      default: begin
        n = 0;
        while ((chk.frames_pending() != 0 || lmx_le_o) && n < drain_timeout) begin
          @(negedge wb_clk_i);
          n++;
        end
        if (chk.frames_pending() != 0 || lmx_le_o) begin
          chk.report_failure("queued frames did not all go out in time");
        end
      end
    endcase
  endtask

  initial begin
    wb_rst_i     = 1'b1;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_sel_i     = 4'h0;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    lmx_muxout_i = 1'b0;
    seed_val     = $urandom(32'hee853ffb);
    build_table();
    repeat (4) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    for (int i = 0; i < n_steps; i++) begin
      run_step(i);
    end
    $display("checks %0d, errors %0d", chk.check_count, chk.error_count);
    if (chk.error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
source/lmx_pkg.sv
source/lmx_wb_regs.sv
source/lmx_cmd_fifo.sv
source/lmx_spi_shifter.sv
source/lmx_spi_ctrl_top.sv
test/lmx_spi_checker.sv
test/lmx_tb.sv

/* Bender.yml */
package:
  name: lmx_spi_ctrl

sources:
  - files:
      - source/lmx_pkg.sv
      - source/lmx_wb_regs.sv
      - source/lmx_cmd_fifo.sv
      - source/lmx_spi_shifter.sv
      - source/lmx_spi_ctrl_top.sv
  - target: test
    files:
      - test/lmx_spi_checker.sv
      - test/lmx_tb.sv
